//--- hw/cpu_bus_pkg.sv
// ------------------------------
// cpu bus widths and types
// data word, word address, strobes
// ------------------------------
`default_nettype none

package cpu_bus_pkg;

    localparam int bus_data_w = 16;  // 68000 data bus
    localparam int bus_addr_w = 23;  // word address, A23..A1
    localparam int reg_idx_w  = 4;   // A4..A1 pick the register

    typedef logic [bus_data_w-1:0] bus_word_t;
    typedef logic [bus_addr_w:1]   bus_addr_t;  // no A0 on a 16-bit bus

    // active low like the cpu pins, bit 1 is the upper byte (UDS)
    typedef logic [1:0]            byte_en_t;

    typedef logic [reg_idx_w-1:0]  reg_idx_t;

endpackage

`default_nettype wire

//--- hw/cmp_timer_pkg.sv
// ------------------------------
// compare/timer register map
// flag codes, timer and latch types
// ------------------------------
`default_nettype none

package cmp_timer_pkg;

    // register map, word offsets inside the chip window
    localparam cpu_bus_pkg::reg_idx_t reg_bound1       = 4'd0;
    localparam cpu_bus_pkg::reg_idx_t reg_bound2       = 4'd1;
    localparam cpu_bus_pkg::reg_idx_t reg_value        = 4'd2;
    localparam cpu_bus_pkg::reg_idx_t reg_flags        = 4'd3;   // read only
    localparam cpu_bus_pkg::reg_idx_t reg_history      = 4'd4;   // write clears
    localparam cpu_bus_pkg::reg_idx_t reg_bound2_alias = 4'd5;
    localparam cpu_bus_pkg::reg_idx_t reg_value_alias  = 4'd6;
    localparam cpu_bus_pkg::reg_idx_t reg_clamped      = 4'd7;   // read only
    localparam cpu_bus_pkg::reg_idx_t reg_reload       = 4'd8;
    localparam cpu_bus_pkg::reg_idx_t reg_irq_ack      = 4'd9;   // read acks main irq
    localparam cpu_bus_pkg::reg_idx_t reg_timer_ctrl   = 4'd10;  // bit 0 enables count
    localparam cpu_bus_pkg::reg_idx_t reg_reload_alias = 4'd12;
    localparam cpu_bus_pkg::reg_idx_t reg_irq_ack_alias = 4'd14;
    localparam cpu_bus_pkg::reg_idx_t reg_snd_latch    = 4'd15;

    // flag word, one bit per side, zero when in range
    localparam cpu_bus_pkg::bus_word_t flag_below  = 16'h8000;
    localparam cpu_bus_pkg::bus_word_t flag_above  = 16'h4000;
    localparam cpu_bus_pkg::bus_word_t flag_inside = 16'h0000;

    localparam int timer_w = 12;  // hidden counter, wraps at all ones
    localparam int snd_w   = 8;   // sound cpu sees one byte

    typedef logic [timer_w-1:0] timer_t;
    typedef logic [snd_w-1:0]   snd_byte_t;

endpackage

`default_nettype wire

//--- hw/cpu_bus_decode.sv
// ------------------------------
// cpu bus decode
// strobes, index and masked data
// ------------------------------
`default_nettype none

module cpu_bus_decode
    import cpu_bus_pkg::*;
    import cmp_timer_pkg::*;
(
    input  wire       cs,           // one cycle per access
    input  wire bus_addr_t addr,
    input  wire byte_en_t  dsn,
    input  wire       rnw,
    input  wire bus_word_t din,

    output logic      wr_stb,
    output logic      rd_stb,
    output reg_idx_t  reg_idx,
    output byte_en_t  wr_mask,      // active high
    output bus_word_t wr_data,
    output logic      irq_ack_stb,
    output logic      snd_wr_stb
);

    reg_idx_t idx;
    byte_en_t mask;
    logic     wr_access;
    logic     rd_access;

    // board logic decodes the upper address bits into cs
    assign idx  = addr[reg_idx_w:1];
    assign mask = ~dsn;

    // no byte lane active means nothing to write
    assign wr_access = cs && !rnw && (mask != 2'b00);
    assign rd_access = cs && rnw;   // reads ignore the byte strobes

    assign wr_stb  = wr_access;
    assign rd_stb  = rd_access;
    assign reg_idx = idx;
    assign wr_mask = mask;

    // idle lanes forced to zero so the core can or in its kept bytes
    assign wr_data = {
        mask[1] ? din[15:8] : 8'h00,
        mask[0] ? din[7:0]  : 8'h00
    };

    // main irq is acknowledged by reading either ack slot
    assign irq_ack_stb = rd_access &&
                         (idx == reg_irq_ack || idx == reg_irq_ack_alias);

    assign snd_wr_stb = wr_access && (idx == reg_snd_latch);

endmodule

`default_nettype wire

//--- hw/cmp_timer_core.sv
// ------------------------------
// compare/clamp, history word,
// reload timer and read mux
// ------------------------------
`default_nettype none

module cmp_timer_core
    import cpu_bus_pkg::*;
    import cmp_timer_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       wr_stb,
    input  wire       rd_stb,
    input  wire reg_idx_t  reg_idx,
    input  wire byte_en_t  wr_mask,
    input  wire bus_word_t wr_data,     // idle lanes already zero
    input  wire       cnt_up,           // external count pulses

    output bus_word_t dout,
    output logic      timer_wrap_stb
);

    bus_word_t  bound1_q;
    bus_word_t  bound2_q;
    bus_word_t  value_q;
    timer_t     reload_q;
    logic       timer_en_q;
    timer_t     timer_q;      // not visible on the bus
    logic       cnt_up_d;
    bus_word_t  flags_q;
    bus_word_t  clamped_q;
    bus_word_t  history_q;
    logic [3:0] hist_idx_q;   // next history bit to fill
    logic       hist_pend_q;

    bus_word_t  cur_word;
    bus_word_t  keep_mask;
    bus_word_t  merged;
    bus_word_t  nx_flags;
    bus_word_t  nx_clamped;
    logic signed [bus_data_w-1:0] b1_s;
    logic signed [bus_data_w-1:0] b2_s;
    logic signed [bus_data_w-1:0] val_s;
    logic signed [bus_data_w-1:0] lo_s;
    logic signed [bus_data_w-1:0] hi_s;
    logic       value_wr;
    logic       hist_clr;
    logic       cnt_edge;

    // current contents of the write target, for byte merging
    always_comb begin
        case (reg_idx)
            reg_bound1:                     cur_word = bound1_q;
            reg_bound2, reg_bound2_alias:   cur_word = bound2_q;
            reg_value, reg_value_alias:     cur_word = value_q;
            reg_reload, reg_reload_alias:   cur_word = bus_word_t'(reload_q);
            reg_timer_ctrl:                 cur_word = bus_word_t'(timer_en_q);
            default:                        cur_word = '0;
        endcase
    end

    assign keep_mask = {{8{~wr_mask[1]}}, {8{~wr_mask[0]}}};
    assign merged    = wr_data | (cur_word & keep_mask);

    // bus writes, aliases land on the same registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bound1_q   <= '0;
            bound2_q   <= '0;
            value_q    <= '0;
            reload_q   <= '0;
            timer_en_q <= 1'b0;
        end else if (wr_stb) begin
            case (reg_idx)
                reg_bound1:                   bound1_q   <= merged;
                reg_bound2, reg_bound2_alias: bound2_q   <= merged;
                reg_value, reg_value_alias:   value_q    <= merged;
                reg_reload, reg_reload_alias: reload_q   <= timer_t'(merged);
                reg_timer_ctrl:               timer_en_q <= merged[0];
                default: ;                    // read only or handled elsewhere
            endcase
        end
    end

    // bounds may come in either order
    assign b1_s  = signed'(bound1_q);
    assign b2_s  = signed'(bound2_q);
    assign val_s = signed'(value_q);
    assign lo_s  = (b1_s < b2_s) ? b1_s : b2_s;
    assign hi_s  = (b1_s < b2_s) ? b2_s : b1_s;

    always_comb begin
        if (val_s < lo_s) begin
            nx_flags   = flag_below;
            nx_clamped = bus_word_t'(lo_s);
        end else if (val_s > hi_s) begin
            nx_flags   = flag_above;
            nx_clamped = bus_word_t'(hi_s);
        end else begin
            nx_flags   = flag_inside;
            nx_clamped = value_q;   // already in range
        end
    end

    assign value_wr = wr_stb && (reg_idx == reg_value || reg_idx == reg_value_alias);
    assign hist_clr = wr_stb && (reg_idx == reg_history);

    // compare result every cycle, history one cycle behind the value update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags_q     <= '0;
            clamped_q   <= '0;
            history_q   <= '0;
            hist_idx_q  <= '0;
            hist_pend_q <= 1'b0;
        end else begin
            flags_q     <= nx_flags;
            clamped_q   <= nx_clamped;
            hist_pend_q <= value_wr;  // value reg is updated by then
            if (hist_clr) begin
                history_q  <= '0;
                hist_idx_q <= '0;
            end else if (hist_pend_q) begin
                history_q[hist_idx_q] <= (nx_flags == flag_inside);
                hist_idx_q <= hist_idx_q + 1'b1;  // wraps after 15
            end
        end
    end

    // read data held until the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (rd_stb) begin
            case (reg_idx)
                reg_bound1:                   dout <= bound1_q;
                reg_bound2, reg_bound2_alias: dout <= bound2_q;
                reg_value, reg_value_alias:   dout <= value_q;
                reg_flags:                    dout <= flags_q;
                reg_history:                  dout <= history_q;
                reg_clamped:                  dout <= clamped_q;
                default:                      dout <= '1;  // floating bus
            endcase
        end
    end

    assign cnt_edge = cnt_up && !cnt_up_d;

    // wrap reloads even when counting is off
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_up_d       <= 1'b0;
            timer_q        <= '0;
            timer_wrap_stb <= 1'b0;
        end else begin
            cnt_up_d       <= cnt_up;
            timer_wrap_stb <= 1'b0;
            if (cnt_edge) begin
                if (&timer_q) begin
                    timer_q        <= reload_q;
                    timer_wrap_stb <= 1'b1;
                end else if (timer_en_q) begin
                    timer_q <= timer_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/irq_snd_latch.sv
// ------------------------------
// main irq latch, sound byte
// latch and sound irq
// ------------------------------
`default_nettype none

module irq_snd_latch
    import cpu_bus_pkg::*;
    import cmp_timer_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       timer_wrap_stb,
    input  wire       irq_ack_stb,   // read of the ack slot
    input  wire       snd_wr_stb,
    input  wire bus_word_t wr_data,
    input  wire       snd_ack,       // from the sound cpu

    output logic      main_irqn,     // active low to the 68000
    output logic      snd_irq,
    output snd_byte_t snd_data
);

    // set beats clear when both land together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            main_irqn <= 1'b1;
        end else if (timer_wrap_stb) begin
            main_irqn <= 1'b0;
        end else if (irq_ack_stb) begin
            main_irqn <= 1'b1;
        end
    end

    // low byte only, upper lane ignored
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_data <= '0;
            snd_irq  <= 1'b0;
        end else begin
            if (snd_wr_stb) begin
                snd_data <= wr_data[snd_w-1:0];
                snd_irq  <= 1'b1;
            end else if (snd_ack) begin
                snd_irq  <= 1'b0;   // sound cpu took the byte
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cmp_timer_top.sv
// ------------------------------
// compare/timer chip top
// decode, core and irq latches
// ------------------------------
`default_nettype none

module cmp_timer_top
    import cpu_bus_pkg::*;
(
    input  wire       clk,
    input  wire       rst,

    // 68000 side
    input  wire       cs,
    input  wire bus_addr_t addr,
    input  wire byte_en_t  dsn,
    input  wire       rnw,
    input  wire bus_word_t din,

    input  wire       cnt_up,
    input  wire       snd_ack,

    output wire bus_word_t  dout,
    output wire       main_irqn,
    output wire       snd_irq,
    output wire logic [7:0] snd_data
);

    wire logic      wr_stb;
    wire logic      rd_stb;
    wire reg_idx_t  reg_idx;
    wire byte_en_t  wr_mask;
    wire bus_word_t wr_data;
    wire logic      irq_ack_stb;
    wire logic      snd_wr_stb;
    wire logic      timer_wrap_stb;

    cpu_bus_decode u_decode (
        .cs          (cs),
        .addr        (addr),
        .dsn         (dsn),
        .rnw         (rnw),
        .din         (din),
        .wr_stb      (wr_stb),
        .rd_stb      (rd_stb),
        .reg_idx     (reg_idx),
        .wr_mask     (wr_mask),
        .wr_data     (wr_data),
        .irq_ack_stb (irq_ack_stb),
        .snd_wr_stb  (snd_wr_stb)
    );

    cmp_timer_core u_core (
        .clk            (clk),
        .rst            (rst),
        .wr_stb         (wr_stb),
        .rd_stb         (rd_stb),
        .reg_idx        (reg_idx),
        .wr_mask        (wr_mask),
        .wr_data        (wr_data),
        .cnt_up         (cnt_up),
        .dout           (dout),
        .timer_wrap_stb (timer_wrap_stb)
    );

    irq_snd_latch u_irq (
        .clk            (clk),
        .rst            (rst),
        .timer_wrap_stb (timer_wrap_stb),
        .irq_ack_stb    (irq_ack_stb),
        .snd_wr_stb     (snd_wr_stb),
        .wr_data        (wr_data),
        .snd_ack        (snd_ack),
        .main_irqn      (main_irqn),
        .snd_irq        (snd_irq),
        .snd_data       (snd_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
// ------------------------------
// testbench clock source
// 10 ns period
// ------------------------------
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 5;  // ns

    initial clk = 1'b0;

    always #half_period clk = ~clk;

endmodule

`default_nettype wire

//--- verif/tb_cmp_timer.sv
// ------------------------------
// testbench for the compare/timer chip
// random bus traffic, reference model,
// checks, watchdog and report
// ------------------------------
`default_nettype none

module tb_cmp_timer
    import cpu_bus_pkg::*;
    import cmp_timer_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_rw          = 40;
    localparam int n_cmp         = 40;
    localparam int n_hist_rounds = 3;
    localparam int n_snd         = 10;
    localparam int n_frozen      = 256;  // covers the longest reload to wrap run

    // cycle budget per test, bus write 2 cycles, read 1, count pulse 2
    localparam int cycles_reset = 10;
    localparam int cycles_t1    = 16 + 4;
    localparam int cycles_t2    = n_rw * 3;
    localparam int cycles_t3    = n_cmp * 8;
    localparam int cycles_t4    = n_hist_rounds * (8 + 20 * 2);
    localparam int cycles_t5    = 10 + (4096 + 256 + n_frozen) * 2;
    localparam int cycles_t6    = n_snd * 4 + 4;
    localparam int watchdog_ns  = (cycles_reset + cycles_t1 + cycles_t2 + cycles_t3 +
                                   cycles_t4 + cycles_t5 + cycles_t6) * 10 + 2000;

    wire       clk;
    logic      rst;
    logic      cs;
    bus_addr_t addr;
    byte_en_t  dsn;
    logic      rnw;
    bus_word_t din;
    logic      cnt_up;
    logic      snd_ack;
    wire bus_word_t dout;
    wire       main_irqn;
    wire       snd_irq;
    wire snd_byte_t snd_data;

    // reference model state
    bus_word_t  m_bound1;
    bus_word_t  m_bound2;
    bus_word_t  m_value;
    bus_word_t  m_history;
    logic [3:0] m_hist_idx;      // next history slot
    timer_t     m_reload;
    timer_t     m_timer;
    logic       m_timer_en;
    logic       m_irqn;
    logic       m_snd_irq;
    snd_byte_t  m_snd_data;

    integer seed;
    int     errors;
    int     test_errors;
    int     checks;
    int     tests_run;
    int     tests_failed;

    tb_clk_gen u_clk (
        .clk (clk)
    );

    cmp_timer_top dut (
        .clk       (clk),
        .rst       (rst),
        .cs        (cs),
        .addr      (addr),
        .dsn       (dsn),
        .rnw       (rnw),
        .din       (din),
        .cnt_up    (cnt_up),
        .snd_ack   (snd_ack),
        .dout      (dout),
        .main_irqn (main_irqn),
        .snd_irq   (snd_irq),
        .snd_data  (snd_data)
    );

    function automatic int rand_below(int n);
        return int'(($random(seed) & 32'h7fff_ffff) % n);
    endfunction

    function automatic bus_word_t rand_word();
        return bus_word_t'($random(seed));
    endfunction

    // one of the five bound/value slots, aliases included
    function automatic reg_idx_t data_reg(int k);
        case (k)
            0:       return reg_bound1;
            1:       return reg_bound2;
            2:       return reg_value;
            3:       return reg_bound2_alias;
            default: return reg_value_alias;
        endcase
    endfunction

    // dsn low means the lane is written
    function automatic bus_word_t merge_bytes(bus_word_t old, bus_word_t data,
                                             byte_en_t strobes_n);
        bus_word_t lanes;
        lanes = {{8{~strobes_n[1]}}, {8{~strobes_n[0]}}};
        return (data & lanes) | (old & ~lanes);
    endfunction

    // {flags, clamped} for signed bounds in either order
    function automatic logic [31:0] ref_compare(bus_word_t b1, bus_word_t b2, bus_word_t v);
        logic signed [15:0] s1, s2, sv;
        logic signed [15:0] lo, hi;
        s1 = signed'(b1);
        s2 = signed'(b2);
        sv = signed'(v);
        lo = (s2 < s1) ? s2 : s1;
        hi = (s2 < s1) ? s1 : s2;
        if (sv < lo)
            return {flag_below, bus_word_t'(lo)};
        if (sv > hi)
            return {flag_above, bus_word_t'(hi)};
        return {flag_inside, v};
    endfunction

    function automatic bus_word_t model_read(reg_idx_t idx);
        logic [31:0] cmp;
        cmp = ref_compare(m_bound1, m_bound2, m_value);
        case (idx)
            reg_bound1:                   return m_bound1;
            reg_bound2, reg_bound2_alias: return m_bound2;
            reg_value, reg_value_alias:   return m_value;
            reg_flags:                    return cmp[31:16];
            reg_history:                  return m_history;
            reg_clamped:                  return cmp[15:0];
            default:                      return 16'hFFFF;   // not readable
        endcase
    endfunction

    task automatic model_write(reg_idx_t idx, byte_en_t strobes_n, bus_word_t data);
        bus_word_t   tmp;
        logic [31:0] cmp;
        if (strobes_n == 2'b11)
            return;   // no lane, no write
        case (idx)
            reg_bound1:                   m_bound1 = merge_bytes(m_bound1, data, strobes_n);
            reg_bound2, reg_bound2_alias: m_bound2 = merge_bytes(m_bound2, data, strobes_n);
            reg_value, reg_value_alias: begin
                m_value = merge_bytes(m_value, data, strobes_n);
                cmp = ref_compare(m_bound1, m_bound2, m_value);
                m_history[m_hist_idx] = (cmp[31:16] == flag_inside);
                m_hist_idx = m_hist_idx + 4'd1;
            end
            reg_history: begin
                m_history  = '0;
                m_hist_idx = '0;
            end
            reg_reload, reg_reload_alias:
                m_reload = timer_t'(merge_bytes(bus_word_t'(m_reload), data, strobes_n));
            reg_timer_ctrl: begin
                tmp = merge_bytes(bus_word_t'(m_timer_en), data, strobes_n);
                m_timer_en = tmp[0];
            end
            reg_snd_latch: begin
                m_snd_data = strobes_n[0] ? 8'h00 : data[7:0];  // idle low lane reads 0
                m_snd_irq  = 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic check_word(string name, bus_word_t exp, bus_word_t got);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: expected %h, got %h", name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        check_word("main_irqn", bus_word_t'(m_irqn), bus_word_t'(main_irqn));
        check_word("snd_irq", bus_word_t'(m_snd_irq), bus_word_t'(snd_irq));
        check_word("snd_data", bus_word_t'(m_snd_data), bus_word_t'(snd_data));
    endtask

    // cs for one cycle, then one idle cycle
    task automatic bus_write(reg_idx_t idx, byte_en_t strobes_n, bus_word_t data);
        bus_addr_t a;
        a = bus_addr_t'($random(seed));   // upper bits decoded off chip
        a[4:1] = idx;
        cs   = 1'b1;
        rnw  = 1'b0;
        addr = a;
        dsn  = strobes_n;
        din  = data;
        @(negedge clk);
        cs  = 1'b0;
        rnw = 1'b1;
        dsn = 2'b11;
        model_write(idx, strobes_n, data);
        @(negedge clk);
    endtask

    task automatic bus_read(input reg_idx_t idx, output bus_word_t data);
        bus_addr_t a;
        a = bus_addr_t'($random(seed));
        a[4:1] = idx;
        cs   = 1'b1;
        rnw  = 1'b1;
        addr = a;
        dsn  = byte_en_t'(rand_below(4));  // ignored on reads
        @(negedge clk);
        cs   = 1'b0;
        dsn  = 2'b11;
        data = dout;
        if (idx == reg_irq_ack || idx == reg_irq_ack_alias)
            m_irqn = 1'b1;
    endtask

    task automatic check_read(reg_idx_t idx);
        bus_word_t exp;
        bus_word_t got;
        exp = model_read(idx);
        bus_read(idx, got);
        check_word($sformatf("dout[%0d]", idx), exp, got);
    endtask

    // one cnt_up pulse, high for a cycle then low
    task automatic count_pulse(output logic wrapped);
        wrapped = 1'b0;
        cnt_up  = 1'b1;
        if (&m_timer) begin
            m_timer = m_reload;
            m_irqn  = 1'b0;
            wrapped = 1'b1;
        end else if (m_timer_en) begin
            m_timer = m_timer + 12'd1;
        end
        @(negedge clk);
        cnt_up = 1'b0;
        @(negedge clk);   // irq settles one cycle after the wrap strobe
        check_word("main_irqn", bus_word_t'(m_irqn), bus_word_t'(main_irqn));
    endtask

    task automatic run_to_wrap();
        int   pulses;
        logic wrapped;
        pulses  = 0;
        wrapped = 1'b0;
        while (!wrapped && pulses < 5000) begin
            count_pulse(wrapped);
            pulses++;
        end
        $display("  timer wrapped after %0d pulses", pulses);
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog: run still going after %0d ns, simulation hung", watchdog_ns);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        int        n;
        reg_idx_t  idx;
        logic      wrapped;
        timer_t    reload_val;
        seed = 48276;
        errors = 0;
        test_errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        rst     = 1'b1;
        cs      = 1'b0;
        addr    = '0;
        dsn     = 2'b11;
        rnw     = 1'b1;
        din     = '0;
        cnt_up  = 1'b0;
        snd_ack = 1'b0;
        m_bound1 = '0;
        m_bound2 = '0;
        m_value = '0;
        m_history = '0;
        m_hist_idx = '0;
        m_reload = '0;
        m_timer = '0;
        m_timer_en = 1'b0;
        m_irqn = 1'b1;
        m_snd_irq = 1'b0;
        m_snd_data = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // all indices, readable ones zero
        check_outputs();
        for (int i = 0; i < 16; i++)
            check_read(reg_idx_t'(i));
        check_outputs();
        finish_test("reset values");

        // byte merged writes, read back through any alias
        repeat (n_rw) begin
            bus_write(data_reg(rand_below(5)), byte_en_t'(rand_below(4)), rand_word());
            check_read(data_reg(rand_below(5)));
        end
        finish_test("masked writes");

        repeat (n_cmp) begin
            bus_write(reg_bound1, 2'b00, rand_word());
            bus_write((rand_below(2) != 0) ? reg_bound2_alias : reg_bound2, 2'b00, rand_word());
            bus_write((rand_below(2) != 0) ? reg_value_alias : reg_value, 2'b00, rand_word());
            check_read(reg_flags);
            check_read(reg_clamped);
        end
        finish_test("compare and clamp");

        repeat (n_hist_rounds) begin
            bus_write(reg_bound1, 2'b00, rand_word());
            bus_write(reg_bound2, 2'b00, rand_word());
            bus_write(reg_history, 2'b00, rand_word());   // any data clears
            check_read(reg_history);
            n = 1 + rand_below(20);                        // past 16 to see the wrap
            repeat (n)
                bus_write((rand_below(2) != 0) ? reg_value_alias : reg_value, 2'b00, rand_word());
            check_read(reg_history);
        end
        finish_test("history word");

        // reload kept high so the second wrap comes quickly
        reload_val = 12'hF00 | timer_t'($random(seed) & 32'h7F);
        idx = (rand_below(2) != 0) ? reg_reload_alias : reg_reload;
        bus_write(idx, 2'b00, {4'hA, reload_val});
        bus_write(reg_timer_ctrl, 2'b00, 16'h0001);
        run_to_wrap();                                  // from zero
        check_read((rand_below(2) != 0) ? reg_irq_ack_alias : reg_irq_ack);
        check_outputs();
        run_to_wrap();                                  // from the reload value
        check_read((rand_below(2) != 0) ? reg_irq_ack_alias : reg_irq_ack);
        check_outputs();
        bus_write(reg_timer_ctrl, 2'b00, 16'h0000);
        repeat (n_frozen)
            count_pulse(wrapped);                       // frozen, irq stays high
        check_outputs();
        finish_test("timer and main irq");

        repeat (n_snd) begin
            bus_write(reg_snd_latch, byte_en_t'(rand_below(4)), rand_word());
            check_outputs();
            snd_ack   = 1'b1;
            m_snd_irq = 1'b0;
            @(negedge clk);
            snd_ack = 1'b0;
            check_outputs();
        end
        finish_test("sound latch");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/cpu_bus_pkg.sv
hw/cmp_timer_pkg.sv
hw/cpu_bus_decode.sv
hw/cmp_timer_core.sv
hw/irq_snd_latch.sv
hw/cmp_timer_top.sv
verif/tb_clk_gen.sv
verif/tb_cmp_timer.sv

//--- run_sim.sh
#!/bin/sh
# build the compare/timer testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_cmp_timer \
    -f flist.f \
    -o sim_cmp_timer

./obj_dir/sim_cmp_timer > sim.log 2>&1
cat sim.log

# verdict comes from the log
if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
